//--- common/secv_pkg.sv
// Shared sizes, memory opcodes, function-unit and bus bundles for the data-memory path
package secv_pkg;

    // Data width of the core
    localparam int XLEN = 64;

    // Word address width on the data bus, 256 words
    localparam int ADR_WIDTH = 8;

    // One select bit per byte lane
    localparam int SEL_WIDTH = XLEN / 8;

    // Memory opcodes
    // Codes 11 to 15 are left undefined and complete with an error
    typedef enum logic [3:0] {
        MEM_OP_LB  = 4'd0,
        MEM_OP_LH  = 4'd1,
        MEM_OP_LW  = 4'd2,
        MEM_OP_LD  = 4'd3,
        MEM_OP_LBU = 4'd4,
        MEM_OP_LHU = 4'd5,
        MEM_OP_LWU = 4'd6,
        MEM_OP_SB  = 4'd7,
        MEM_OP_SH  = 4'd8,
        MEM_OP_SW  = 4'd9,
        MEM_OP_SD  = 4'd10
    } mem_op_t;

    // Request into a function unit
    typedef struct packed {
        logic              ena;
        mem_op_t           op;
        logic [XLEN-1:0]   src1;
        logic [XLEN-1:0]   src2;
    } funit_in_t;

    // Completion out of a function unit
    typedef struct packed {
        logic              rdy;
        logic              err;
        logic [XLEN-1:0]   res;
        logic              res_wb;
    } funit_out_t;

    // Request as seen at the top level
    typedef struct packed {
        mem_op_t           op;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [SEL_WIDTH-1:0]  sel;
        logic [ADR_WIDTH-1:0]  adr;
        logic [XLEN-1:0]       dat;
    } wb_m2s_t;

    // Idle completion, nothing to report
    function automatic funit_out_t funit_out_default();
        funit_out_t r;
        r.rdy    = 1'b0;
        r.err    = 1'b0;
        r.res    = '0;
        r.res_wb = 1'b0;
        return r;
    endfunction

    // Sign extension of a byte
    function automatic logic [XLEN-1:0] sext8(logic [7:0] v);
        return {{(XLEN-8){v[7]}}, v};
    endfunction

    // Sign extension of a half word
    function automatic logic [XLEN-1:0] sext16(logic [15:0] v);
        return {{(XLEN-16){v[15]}}, v};
    endfunction

    // Sign extension of a word
    function automatic logic [XLEN-1:0] sext32(logic [31:0] v);
        return {{(XLEN-32){v[31]}}, v};
    endfunction

endpackage

//--- mem/mem.sv
// Memory function unit, turns one request into a Wishbone classic cycle and extends the load data
module mem (
    // Function unit side
    input  secv_pkg::funit_in_t              fu_i,
    output secv_pkg::funit_out_t             fu_o,

    // Data memory bus
    output secv_pkg::wb_m2s_t                dmem_o,
    input  logic [secv_pkg::XLEN-1:0]        dmem_dat_i,
    input  logic                             dmem_ack_i
);
    import secv_pkg::*;

    logic [XLEN-1:0] load_dat;
    logic            load;
    logic            err;

    // Bus strobes, lane selects and store data
    always_comb begin
        dmem_o     = '0;
        load_dat   = '0;
        load       = 1'b0;
        err        = 1'b0;

        if (fu_i.ena) begin
            dmem_o.cyc = 1'b1;
            dmem_o.stb = 1'b1;
            dmem_o.adr = fu_i.src1[ADR_WIDTH-1:0];

            unique case (fu_i.op)
                // Sign-extending loads
                MEM_OP_LB: begin
                    load_dat   = sext8(dmem_dat_i[7:0]);
                    dmem_o.sel = 8'h01;
                    load       = 1'b1;
                end

                MEM_OP_LH: begin
                    load_dat   = sext16(dmem_dat_i[15:0]);
                    dmem_o.sel = 8'h03;
                    load       = 1'b1;
                end

                MEM_OP_LW: begin
                    load_dat   = sext32(dmem_dat_i[31:0]);
                    dmem_o.sel = 8'h0f;
                    load       = 1'b1;
                end

                MEM_OP_LD: begin
                    load_dat   = dmem_dat_i;
                    dmem_o.sel = 8'hff;
                    load       = 1'b1;
                end

                // Zero-extending loads
                MEM_OP_LBU: begin
                    load_dat   = XLEN'(dmem_dat_i[7:0]);
                    dmem_o.sel = 8'h01;
                    load       = 1'b1;
                end

                MEM_OP_LHU: begin
                    load_dat   = XLEN'(dmem_dat_i[15:0]);
                    dmem_o.sel = 8'h03;
                    load       = 1'b1;
                end

                MEM_OP_LWU: begin
                    load_dat   = XLEN'(dmem_dat_i[31:0]);
                    dmem_o.sel = 8'h0f;
                    load       = 1'b1;
                end

                // Stores, always into the low lanes
                MEM_OP_SB: begin
                    dmem_o.dat = XLEN'(fu_i.src2[7:0]);
                    dmem_o.sel = 8'h01;
                    dmem_o.we  = 1'b1;
                end

                MEM_OP_SH: begin
                    dmem_o.dat = XLEN'(fu_i.src2[15:0]);
                    dmem_o.sel = 8'h03;
                    dmem_o.we  = 1'b1;
                end

                MEM_OP_SW: begin
                    dmem_o.dat = XLEN'(fu_i.src2[31:0]);
                    dmem_o.sel = 8'h0f;
                    dmem_o.we  = 1'b1;
                end

                MEM_OP_SD: begin
                    dmem_o.dat = fu_i.src2;
                    dmem_o.sel = 8'hff;
                    dmem_o.we  = 1'b1;
                end

                // Undefined code, no lanes, finish at once
                default: begin
                    err = 1'b1;
                end
            endcase
        end
    end

    // Completion back to the issue stage
    always_comb begin
        fu_o = funit_out_default();

        if (fu_i.ena) begin
            fu_o.rdy    = err || dmem_ack_i;
            fu_o.err    = err;
            fu_o.res    = load_dat;
            fu_o.res_wb = load && !err;
        end
    end

    // No bus strobe without an active request
    always_comb begin
        assert final (!dmem_o.stb || fu_i.ena)
            else $error("mem: stb high without an active request");
    end

endmodule

//--- source/mem_issue.sv
// Issue stage, holds one memory request steady until the unit is ready and registers the result
module mem_issue (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Request side
    input  logic                  req_valid_i,
    input  secv_pkg::mem_req_t    req_i,
    output logic                  busy_o,

    // Function unit side
    output secv_pkg::funit_in_t   fu_o,
    input  secv_pkg::funit_out_t  fu_res_i,

    // Registered completion
    output secv_pkg::funit_out_t  res_o
);
    import secv_pkg::*;

    logic        busy_q;
    logic        res_rdy_q;
    mem_req_t    hold_q;
    funit_out_t  res_q;
    logic        accept;
    logic        done;

    // Only one request in flight
    assign accept = req_valid_i && !busy_q;
    assign done   = busy_q && fu_res_i.rdy;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            res_rdy_q <= 1'b0;
        end else begin
            res_rdy_q <= done;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Request and result payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            hold_q <= req_i;
        end
        if (done) begin
            res_q <= fu_res_i;
        end
    end

    always_comb begin
        fu_o.ena  = busy_q;
        fu_o.op   = hold_q.op;
        fu_o.src1 = hold_q.addr;
        fu_o.src2 = hold_q.wdata;
    end

    // rdy is a single-cycle pulse, the rest is held
    always_comb begin
        res_o     = res_q;
        res_o.rdy = res_rdy_q;
    end

    assign busy_o = busy_q;

    // Request must not move until the unit answers
    assert property (@(posedge clk_i) disable iff (rst_i)
        fu_o.ena && !fu_res_i.rdy |=> fu_o.ena && $stable(fu_o))
        else $error("mem_issue: request changed before completion");

    // One completion per request
    assert property (@(posedge clk_i) disable iff (rst_i)
        res_o.rdy |=> !res_o.rdy)
        else $error("mem_issue: result pulse longer than one cycle");

endmodule

//--- source/dmem_ram.sv
// Data RAM, Wishbone classic slave of 64-bit words with byte-lane writes and a registered ack
module dmem_ram (
    input  logic                         clk_i,
    input  logic                         rst_i,

    // Wishbone slave port
    input  secv_pkg::wb_m2s_t            wb_i,
    output logic [secv_pkg::XLEN-1:0]    dat_o,
    output logic                         ack_o
);
    import secv_pkg::*;

    localparam int DEPTH = 2 ** ADR_WIDTH;

    logic [XLEN-1:0] mem_q [DEPTH];
    logic [XLEN-1:0] dat_q;
    logic            ack_q;
    logic            access;

    // New cycle only while no ack is pending
    assign access = wb_i.cyc && wb_i.stb && !ack_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Storage and read data
    always_ff @(posedge clk_i) begin
        if (access) begin
            if (wb_i.we) begin
                for (int i = 0; i < SEL_WIDTH; i++) begin
                    if (wb_i.sel[i]) begin
                        mem_q[wb_i.adr][8*i +: 8] <= wb_i.dat[8*i +: 8];
                    end
                end
            end else begin
                dat_q <= mem_q[wb_i.adr];
            end
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;

    // A held strobe must not produce a second ack
    assert property (@(posedge clk_i) disable iff (rst_i)
        ack_o |=> !ack_o)
        else $error("dmem_ram: ack high for two cycles");

endmodule

//--- source/secv_mem_top.sv
// Top level of the data-memory path, issue stage, memory unit and data RAM
module secv_mem_top (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Request in
    input  logic                  req_valid_i,
    input  secv_pkg::mem_req_t    req_i,
    output logic                  busy_o,

    // Completion out
    output secv_pkg::funit_out_t  res_o
);
    import secv_pkg::*;

    funit_in_t        fu;
    funit_out_t       fu_res;
    wb_m2s_t          wb;
    logic [XLEN-1:0]  dmem_dat;
    logic             dmem_ack;

    mem_issue u_issue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .busy_o      (busy_o),
        .fu_o        (fu),
        .fu_res_i    (fu_res),
        .res_o       (res_o)
    );

    // Combinational, no clock
    mem u_mem (
        .fu_i        (fu),
        .fu_o        (fu_res),
        .dmem_o      (wb),
        .dmem_dat_i  (dmem_dat),
        .dmem_ack_i  (dmem_ack)
    );

    dmem_ram u_ram (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wb_i        (wb),
        .dat_o       (dmem_dat),
        .ack_o       (dmem_ack)
    );

endmodule

//--- verif/mem_model.svh
// Reference model of the data RAM with the load extension and store lane rules
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// Mirror of every RAM word, indexed by the word address
logic [63:0] model_mem [256];

function automatic bit is_defined(mem_op_t op);
    case (op)
        MEM_OP_LB, MEM_OP_LH, MEM_OP_LW, MEM_OP_LD,
        MEM_OP_LBU, MEM_OP_LHU, MEM_OP_LWU,
        MEM_OP_SB, MEM_OP_SH, MEM_OP_SW, MEM_OP_SD: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic bit is_store(mem_op_t op);
    return op inside {MEM_OP_SB, MEM_OP_SH, MEM_OP_SW, MEM_OP_SD};
endfunction

// Loads only look at the low lanes of the word
function automatic logic [63:0] predict_load(mem_op_t op, logic [63:0] w);
    case (op)
        MEM_OP_LB:  return {{56{w[7]}}, w[7:0]};
        MEM_OP_LH:  return {{48{w[15]}}, w[15:0]};
        MEM_OP_LW:  return {{32{w[31]}}, w[31:0]};
        MEM_OP_LBU: return {56'd0, w[7:0]};
        MEM_OP_LHU: return {48'd0, w[15:0]};
        MEM_OP_LWU: return {32'd0, w[31:0]};
        default:    return w;
    endcase
endfunction

// Stores replace the low lanes and keep the rest of the old word
function automatic logic [63:0] predict_store(mem_op_t op, logic [63:0] old,
                                              logic [63:0] data);
    logic [63:0] mask;
    case (op)
        MEM_OP_SB: mask = 64'h0000_0000_0000_00ff;
        MEM_OP_SH: mask = 64'h0000_0000_0000_ffff;
        MEM_OP_SW: mask = 64'h0000_0000_ffff_ffff;
        MEM_OP_SD: mask = 64'hffff_ffff_ffff_ffff;
        default:   mask = 64'h0;
    endcase
    return (old & ~mask) | (data & mask);
endfunction

// Completion expected for one request against the current word
function automatic funit_out_t predict_result(mem_op_t op, logic [63:0] word);
    funit_out_t r;
    r.rdy    = 1'b1;
    r.err    = !is_defined(op);
    r.res    = 64'h0;
    r.res_wb = 1'b0;
    if (is_defined(op) && !is_store(op)) begin
        r.res    = predict_load(op, word);
        r.res_wb = 1'b1;
    end
    return r;
endfunction

`endif

//--- verif/secv_mem_tb.sv
// Testbench of the data-memory path that checks random requests against a reference model
module secv_mem_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import secv_pkg::*;

    localparam int TIMEOUT    = 20;
    localparam int NUM_RANDOM = 400;

    logic        clk;
    logic        rst;
    logic        req_valid;
    mem_req_t    req;
    logic        busy;
    funit_out_t  res;

    integer seed = 23749;
    int     errors;
    int     tests;
    bit     test_ok;
    bit     timed_out;

    `include "mem_model.svh"

    secv_mem_top dut0 (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .busy_o      (busy),
        .res_o       (res)
    );

    always #5 clk = ~clk;

    task automatic compare_res(input string name, input funit_out_t exp, input funit_out_t act);
        string exp_txt;
        string act_txt;
        if (act !== exp) begin
            exp_txt = $sformatf("rdy=%0b err=%0b res=%h res_wb=%0b",
                                exp.rdy, exp.err, exp.res, exp.res_wb);
            act_txt = $sformatf("rdy=%0b err=%0b res=%h res_wb=%0b",
                                act.rdy, act.err, act.res, act.res_wb);
            $display("FAILED %s: expected %s, actual %s", name, exp_txt, act_txt);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic compare_busy(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    // Number of clock edges from acceptance up to the visible result pulse
    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s latency: expected %0d, actual %0d", name, exp, act);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_ok) begin
            $display("%s ok", name);
        end else begin
            $display("%s mismatch", name);
        end
    endtask

    function automatic mem_req_t random_request();
        mem_req_t r;
        r.op    = mem_op_t'(4'($random(seed)));
        r.addr  = {$random(seed), $random(seed)};
        r.wdata = {$random(seed), $random(seed)};
        return r;
    endfunction

    task automatic wait_idle(input string name);
        int n;
        n = 0;
        while (busy !== 1'b0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("Timeout in %s: busy stayed high for %0d cycles", name, TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // Issue one request, offer junk while busy, then check timing and result
    task automatic issue_request(input string name, input mem_req_t r);
        funit_out_t  exp;
        logic [7:0]  idx;
        int          edges;
        bit          got;
        test_ok = 1'b1;
        idx     = r.addr[7:0];
        exp     = predict_result(r.op, model_mem[idx]);
        wait_idle(name);
        if (timed_out) begin
            return;
        end
        req_valid = 1'b1;
        req       = r;
        edges     = 0;
        got       = 1'b0;
        while (!got && edges < TIMEOUT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (res.rdy === 1'b1) begin
                got = 1'b1;
            end else begin
                compare_busy(name, 1'b1, busy);
                // Must be ignored while busy
                req = random_request();
            end
        end
        req_valid = 1'b0;
        if (!got) begin
            $display("Timeout in %s: no result pulse within %0d cycles", name, TIMEOUT);
            errors++;
            timed_out = 1'b1;
            return;
        end
        check_latency(name, is_defined(r.op) ? 3 : 2, edges);
        compare_res(name, exp, res);
        compare_busy(name, 1'b0, busy);
        if (is_store(r.op)) begin
            model_mem[idx] = predict_store(r.op, model_mem[idx], r.wdata);
        end
        finish_test(name);
    endtask

    initial begin
        mem_req_t r;
        mem_req_t chk;
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        errors    = 0;
        tests     = 0;
        test_ok   = 1'b1;
        timed_out = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Nothing moves before the first request
        repeat (3) begin
            @(negedge clk);
            compare_busy("after_reset_busy", 1'b0, busy);
            compare_busy("after_reset_rdy", 1'b0, res.rdy);
        end
        finish_test("after_reset");

        // Define every word of the model
        for (int a = 0; a < 256 && !timed_out; a++) begin
            r.op    = MEM_OP_SD;
            r.addr  = 64'(a);
            r.wdata = {$random(seed), $random(seed)};
            issue_request($sformatf("init_sd_%0d", a), r);
        end

        for (int n = 0; n < NUM_RANDOM && !timed_out; n++) begin
            r = random_request();
            issue_request($sformatf("rand_%0d_%s", n,
                          is_defined(r.op) ? r.op.name() : "UNDEF"), r);
            // Read back after stores and undefined codes
            if (!timed_out && (is_store(r.op) || !is_defined(r.op))) begin
                chk.op    = MEM_OP_LD;
                chk.addr  = r.addr;
                chk.wdata = 64'h0;
                issue_request($sformatf("readback_%0d", n), chk);
            end
        end

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verif
common/secv_pkg.sv
mem/mem.sv
source/mem_issue.sv
source/dmem_ram.sv
source/secv_mem_top.sv
verif/secv_mem_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the data-memory path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module secv_mem_tb -Mdir obj_dir

status=0
./obj_dir/Vsecv_mem_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
